// File: tb.f
source/rtos_pkg.sv
source/rtos_bus_decode.sv
source/rtos_ready_queue.sv
source/rtos_semaphores.sv
source/rtos_event_flags.sv
source/rtos_cpu_ctl.sv
source/rtos_top.sv
bench/rtos_props.sv
bench/tb_rtos.sv

// File: bench/tb_rtos.sv
// directed testbench for the rtos helper: bus tasks, reference model and checks
`timescale 1ns/1ns

module tb_rtos;
    import rtos_pkg::*;

    localparam int CYCLE_LIMIT = 2000;

    logic                    clk;
    logic                    reset_i;
    wb_req_t                 wb_req_i;
    logic [WB_DAT_WIDTH-1:0] wb_dat_o;
    logic                    wb_ack_o;
    logic [FLGPTN_WIDTH-1:0] ext_flg_i;
    logic                    irq_o;
    rtos_monitor_t           monitor_o;

    // reference model of the kernel objects
    logic [TASKS-1:0]        model_ready;
    int                      model_cnt [SEMAPHORES];
    logic [FLGPTN_WIDTH-1:0] model_flg;
    logic [TSKID_WIDTH-1:0]  model_run_id;
    logic                    model_run_valid;
    logic [WB_DAT_WIDTH-1:0] model_scratch0;
    int                      cycles;

    rtos_top UUT (
        .clk       (clk),
        .reset_i   (reset_i),
        .wb_req_i  (wb_req_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .ext_flg_i (ext_flg_i),
        .irq_o     (irq_o),
        .monitor_o (monitor_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    // --------------------
    // bus access
    // --------------------
    function automatic logic [WB_ADR_WIDTH-1:0] adr_of(input opcode_e op,
                                                        input logic [ID_WIDTH-1:0] id);
        return {op, id};
    endfunction

    task automatic wb_write(input logic [WB_ADR_WIDTH-1:0] adr,
                            input logic [WB_DAT_WIDTH-1:0] dat);
        @(negedge clk);
        wb_req_i.adr = adr;
        wb_req_i.dat = dat;
        wb_req_i.we  = 1'b1;
        wb_req_i.sel = '1;
        wb_req_i.stb = 1'b1;
        #2;
        check_bit("bus write ack", 1'b1, wb_ack_o);
        @(negedge clk);
        wb_req_i.stb = 1'b0;
        wb_req_i.we  = 1'b0;
    endtask

    // data is combinational, so sample mid cycle before the edge
    task automatic wb_read(input logic [WB_ADR_WIDTH-1:0] adr,
                           output logic [WB_DAT_WIDTH-1:0] dat);
        @(negedge clk);
        wb_req_i.adr = adr;
        wb_req_i.we  = 1'b0;
        wb_req_i.sel = '1;
        wb_req_i.stb = 1'b1;
        #2;
        dat = wb_dat_o;
        check_bit("bus read ack", 1'b1, wb_ack_o);
        @(negedge clk);
        wb_req_i.stb = 1'b0;
    endtask

    // --------------------
    // checks
    // --------------------
    task automatic check_word(input string name, input logic [WB_DAT_WIDTH-1:0] exp,
                              input logic [WB_DAT_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "word mismatch in %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "bit mismatch in %s", name);
        end
    endtask

    task automatic check_monitor(input string name, input rtos_monitor_t exp,
                                 input rtos_monitor_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "monitor mismatch in %s", name);
        end
    endtask

    // lowest ready id is the top, -1 when nothing is ready
    function automatic int lowest_ready();
        for (int i = 0; i < TASKS; i++) begin
            if (model_ready[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic [WB_DAT_WIDTH-1:0] packed_counts();
        logic [WB_DAT_WIDTH-1:0] w;
        w = '0;
        for (int k = 0; k < SEMAPHORES; k++) begin
            w[4*k +: 4] = model_cnt[k][3:0];
        end
        return w;
    endfunction

    function automatic rtos_monitor_t expected_monitor();
        rtos_monitor_t m;
        int            top;
        top         = lowest_ready();
        m           = '0;
        m.top_valid = top >= 0;
        m.top_tskid = (top >= 0) ? top[TSKID_WIDTH-1:0] : 4'd15;
        m.run_valid = model_run_valid;
        m.run_tskid = model_run_valid ? model_run_id : 4'd15;
        for (int k = 0; k < SEMAPHORES; k++) begin
            m.semcnt[k] = model_cnt[k][3:0];
        end
        m.flgptn   = model_flg;
        m.scratch0 = model_scratch0;
        return m;
    endfunction

    task automatic check_state(input string name);
        #1;
        check_monitor(name, expected_monitor(), monitor_o);
    endtask

    task automatic check_top(input string name);
        int                      top;
        logic [WB_DAT_WIDTH-1:0] rd;
        top = lowest_ready();
        wb_read(adr_of(OP_CPU_CTL, CTL_TOP_TSKID), rd);
        check_word({name, " top id"}, (top >= 0) ? WB_DAT_WIDTH'(top) : 32'd15, rd);
        wb_read(adr_of(OP_CPU_CTL, CTL_TOP_VALID), rd);
        check_word({name, " top valid"}, (top >= 0) ? 32'd1 : 32'd0, rd);
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_config();
        logic [WB_DAT_WIDTH-1:0] rd;
        wb_read(adr_of(OP_SYS_CFG, CFG_CORE_ID), rd);
        check_word("config core id", 32'h834f5452, rd);
        wb_read(adr_of(OP_SYS_CFG, CFG_VERSION), rd);
        check_word("config version", 32'h0, rd);
        wb_read(adr_of(OP_SYS_CFG, CFG_DATE), rd);
        check_word("config date", 32'h20211120, rd);
        wb_read(adr_of(OP_SYS_CFG, CFG_TASKS), rd);
        check_word("config tasks", 32'd15, rd);
        wb_read(adr_of(OP_SYS_CFG, CFG_SEMAPHORES), rd);
        check_word("config semaphores", 32'd8, rd);
        wb_read(adr_of(OP_SYS_CFG, CFG_SEMCNT_WIDTH), rd);
        check_word("config semcnt width", 32'd4, rd);
        wb_read(adr_of(OP_SYS_CFG, CFG_FLGPTN_WIDTH), rd);
        check_word("config flgptn width", 32'd32, rd);
        wb_read(adr_of(OP_SYS_CFG, 8'h02), rd);
        check_word("config unknown id", 32'h0, rd);
        wb_read(16'h7f00, rd);
        check_word("config unknown opcode", 32'h0, rd);
    endtask

    task automatic test_ready_queue();
        logic [TASKS-1:0] wake_set;
        wake_set = TASKS'($urandom);
        wake_set[$urandom % TASKS] = 1'b1;
        for (int i = 0; i < TASKS; i++) begin
            if (wake_set[i]) begin
                wb_write(adr_of(OP_WUP_TSK, 8'(i)), '0);
                model_ready[i] = 1'b1;
            end
        end
        check_top("ready queue wake");
        for (int i = 0; i < TASKS; i++) begin
            if (model_ready[i]) begin
                wb_write(adr_of(OP_SLP_TSK, 8'(i)), '0);
                model_ready[i] = 1'b0;
                check_top("ready queue sleep");
            end
        end
        // id 20 is out of range and must be dropped
        wb_write(adr_of(OP_WUP_TSK, 8'd20), '0);
        check_top("ready queue wake id 20");
        check_state("ready queue final");
    endtask

    task automatic test_semaphores();
        int                      n;
        logic [WB_DAT_WIDTH-1:0] rd;
        for (int k = 0; k < SEMAPHORES; k++) begin
            // semaphore 0 always runs into saturation
            n = (k == 0) ? 18 : int'($urandom % 20);
            for (int j = 0; j < n; j++) begin
                wb_write(adr_of(OP_SIG_SEM, 8'(k)), '0);
                if (model_cnt[k] < 15) begin
                    model_cnt[k]++;
                end
            end
        end
        wb_read(adr_of(OP_REF_SEMCNT, 8'h00), rd);
        check_word("semaphores counts after signal", packed_counts(), rd);
        check_state("semaphores monitor after signal");
        for (int k = 0; k < SEMAPHORES; k++) begin
            while (model_cnt[k] > 0) begin
                wb_read(adr_of(OP_POL_SEM, 8'(k)), rd);
                check_word("semaphores poll with count", 32'd1, rd);
                model_cnt[k]--;
            end
            wb_read(adr_of(OP_POL_SEM, 8'(k)), rd);
            check_word("semaphores poll when empty", 32'd0, rd);
        end
        wb_read(adr_of(OP_REF_SEMCNT, 8'h00), rd);
        check_word("semaphores counts after poll", packed_counts(), rd);
    endtask

    task automatic test_flags();
        logic [FLGPTN_WIDTH-1:0] pattern;
        logic [FLGPTN_WIDTH-1:0] ena;
        pattern = $urandom;
        wb_write(adr_of(OP_SET_FLG, 8'h00), pattern);
        model_flg = model_flg | pattern;
        check_state("flags set");
        pattern = $urandom;
        wb_write(adr_of(OP_CLR_FLG, 8'h00), pattern);
        model_flg = model_flg & pattern;
        check_state("flags clear by mask");
        wb_write(adr_of(OP_CLR_FLG, 8'h00), '0);
        model_flg = '0;
        ena = $urandom;
        wb_write(adr_of(OP_ENA_FLG_EXT, 8'h00), ena);
        check_state("flags enable mask");
        pattern = $urandom;
        @(negedge clk);
        ext_flg_i = pattern;
        @(negedge clk);
        model_flg = model_flg | (pattern & ena);
        check_state("flags external merge");
        @(negedge clk);
        ext_flg_i = '0;
    endtask

    task automatic test_cpu_ctl();
        logic [WB_DAT_WIDTH-1:0] rd;
        logic [WB_DAT_WIDTH-1:0] value;
        for (int s = 0; s < 4; s++) begin
            value = $urandom;
            wb_write(adr_of(OP_CPU_CTL, 8'(8'he0 + s)), value);
            if (s == 0) begin
                model_scratch0 = value;
            end
            wb_read(adr_of(OP_CPU_CTL, 8'(8'he0 + s)), rd);
            check_word("cpu_ctl scratch read back", value, rd);
        end
        wb_write(adr_of(OP_CPU_CTL, CTL_IRQ_EN), 32'd1);
        wb_read(adr_of(OP_CPU_CTL, CTL_IRQ_EN), rd);
        check_word("cpu_ctl irq enable", 32'd1, rd);

        // run id 16 is out of range, register keeps its low bits
        wb_write(adr_of(OP_CPU_CTL, CTL_RUN_TSKID), 32'd16);
        model_run_id    = 4'd0;
        model_run_valid = 1'b0;
        wb_read(adr_of(OP_CPU_CTL, CTL_RUN_VALID), rd);
        check_word("cpu_ctl run valid after id 16", 32'd0, rd);
        wb_read(adr_of(OP_CPU_CTL, CTL_RUN_TSKID), rd);
        check_word("cpu_ctl run id after id 16", 32'd15, rd);
        check_state("cpu_ctl state after id 16");
        check_bit("cpu_ctl irq idle", 1'b0, irq_o);

        // --------------------
        // switch request
        // --------------------
        wb_write(adr_of(OP_WUP_TSK, 8'd3), '0);
        model_ready[3] = 1'b1;
        #1;
        check_bit("cpu_ctl irq at mismatch edge", 1'b0, irq_o);
        @(negedge clk);
        #1;
        check_bit("cpu_ctl irq one edge later", 1'b0, irq_o);
        @(negedge clk);
        #1;
        check_bit("cpu_ctl irq two edges later", 1'b1, irq_o);

        wb_read(adr_of(OP_CPU_CTL, CTL_COPY_TSKID), rd);
        model_run_id    = 4'd3;
        model_run_valid = 1'b1;
        @(negedge clk);
        #1;
        check_bit("cpu_ctl irq after copy", 1'b0, irq_o);
        wb_read(adr_of(OP_CPU_CTL, CTL_RUN_TSKID), rd);
        check_word("cpu_ctl run id after copy", 32'd3, rd);
        wb_read(adr_of(OP_CPU_CTL, CTL_RUN_VALID), rd);
        check_word("cpu_ctl run valid after copy", 32'd1, rd);
        check_state("cpu_ctl state after copy");

        wb_write(adr_of(OP_CPU_CTL, CTL_IRQ_FORCE), 32'd1);
        #1;
        check_bit("cpu_ctl irq forced", 1'b1, irq_o);
        wb_read(adr_of(OP_CPU_CTL, CTL_IRQ_STS), rd);
        check_word("cpu_ctl irq status forced", 32'd1, rd);
        wb_write(adr_of(OP_CPU_CTL, CTL_IRQ_FORCE), 32'd0);
        #1;
        check_bit("cpu_ctl irq force released", 1'b0, irq_o);
    endtask

    initial begin
        int seed;
        seed = 72671;
        void'($urandom(seed));
        reset_i   = 1'b1;
        wb_req_i  = '0;
        ext_flg_i = '0;
        cycles    = 0;

        model_ready     = '0;
        model_flg       = '0;
        model_run_id    = '0;
        model_run_valid = 1'b0;
        model_scratch0  = '0;
        for (int k = 0; k < SEMAPHORES; k++) begin
            model_cnt[k] = 0;
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        test_config();
        test_ready_queue();
        test_semaphores();
        test_flags();
        test_cpu_ctl();

        @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: bench/rtos_props.sv
// bound assertions on the rtos helper top level: ack, irq after reset, irq force
`timescale 1ns/1ns

module rtos_props (
    input logic              clk,
    input logic              reset_i,
    input rtos_pkg::wb_req_t wb_req_i,
    input logic              wb_ack_o,
    input logic              irq_o
);
    import rtos_pkg::*;

    logic force_wr;

    // full select write of a 1 into the force register
    assign force_wr = wb_req_i.stb && wb_req_i.we && (&wb_req_i.sel)
                      && wb_req_i.adr == {OP_CPU_CTL, CTL_IRQ_FORCE} && wb_req_i.dat[0];

    ack_follows_stb: assert property (@(posedge clk) wb_ack_o == wb_req_i.stb)
        else $error("ack differs from stb");

    irq_low_after_reset: assert property (@(posedge clk) reset_i |=> !irq_o)
        else $error("irq high during or right after reset");

    irq_follows_force: assert property (@(posedge clk) disable iff (reset_i)
                                        force_wr |=> irq_o)
        else $error("irq did not rise one edge after the force write");

endmodule

bind rtos_top rtos_props u_props (
    .clk      (clk),
    .reset_i  (reset_i),
    .wb_req_i (wb_req_i),
    .wb_ack_o (wb_ack_o),
    .irq_o    (irq_o)
);

// File: source/rtos_top.sv
// rtos helper top level: bus decoder, ready queue, semaphores, flags and cpu control
`timescale 1ns/1ns

module rtos_top (
    input  logic                               clk,
    input  logic                               reset_i,
    input  rtos_pkg::wb_req_t                  wb_req_i,
    output logic [rtos_pkg::WB_DAT_WIDTH-1:0]  wb_dat_o,
    output logic                               wb_ack_o,
    input  logic [rtos_pkg::FLGPTN_WIDTH-1:0]  ext_flg_i,
    output logic                               irq_o,
    output rtos_pkg::rtos_monitor_t            monitor_o
);
    import rtos_pkg::*;

    task_cmd_t               task_cmd;
    sem_cmd_t                sem_cmd;
    flg_cmd_t                flg_cmd;
    cpu_wr_t                 cpu_wr;
    logic                    copy_rd;
    rdq_status_t             rdq;
    cpu_status_t             cpu_st;
    semcnt_vec_t             semcnt;
    logic                    pol_ok;
    logic [FLGPTN_WIDTH-1:0] flgptn;

    rtos_bus_decode u_decode (
        .wb_req_i   (wb_req_i),
        .rdq_i      (rdq),
        .cpu_i      (cpu_st),
        .semcnt_i   (semcnt),
        .pol_ok_i   (pol_ok),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .task_cmd_o (task_cmd),
        .sem_cmd_o  (sem_cmd),
        .flg_cmd_o  (flg_cmd),
        .cpu_wr_o   (cpu_wr),
        .copy_rd_o  (copy_rd)
    );

    rtos_ready_queue u_rdq (
        .clk        (clk),
        .reset_i    (reset_i),
        .task_cmd_i (task_cmd),
        .rdq_o      (rdq)
    );

    rtos_semaphores u_sem (
        .clk       (clk),
        .reset_i   (reset_i),
        .sem_cmd_i (sem_cmd),
        .semcnt_o  (semcnt),
        .pol_ok_o  (pol_ok)
    );

    rtos_event_flags u_flg (
        .clk       (clk),
        .reset_i   (reset_i),
        .flg_cmd_i (flg_cmd),
        .ext_flg_i (ext_flg_i),
        .flgptn_o  (flgptn)
    );

    rtos_cpu_ctl u_cpu (
        .clk       (clk),
        .reset_i   (reset_i),
        .cpu_wr_i  (cpu_wr),
        .copy_rd_i (copy_rd),
        .rdq_i     (rdq),
        .cpu_o     (cpu_st),
        .irq_o     (irq_o)
    );

    // observable state
    assign monitor_o.top_tskid = cpu_st.top_tskid;
    assign monitor_o.top_valid = rdq.top_valid;
    assign monitor_o.run_tskid = cpu_st.run_tskid;
    assign monitor_o.run_valid = cpu_st.run_valid;
    assign monitor_o.semcnt    = semcnt;
    assign monitor_o.flgptn    = flgptn;
    assign monitor_o.scratch0  = cpu_st.scratch[0];

endmodule

// File: source/rtos_cpu_ctl.sv
// cpu control: run and idle task registers, scratch words and task switch irq
`timescale 1ns/1ns

module rtos_cpu_ctl (
    input  logic                  clk,
    input  logic                  reset_i,
    input  rtos_pkg::cpu_wr_t     cpu_wr_i,
    input  logic                  copy_rd_i,
    input  rtos_pkg::rdq_status_t rdq_i,
    output rtos_pkg::cpu_status_t cpu_o,
    output logic                  irq_o
);
    import rtos_pkg::*;

    logic [TSKID_WIDTH-1:0]       run_tskid;
    logic                         run_valid;
    logic [TSKID_WIDTH-1:0]       idle_tskid;
    logic                         irq_en;
    logic                         irq_force;
    logic [3:0][WB_DAT_WIDTH-1:0] scratch;
    logic                         reg_switch;
    logic                         reg_irq;
    logic [TSKID_WIDTH-1:0]       cur_run_tskid;
    logic [TSKID_WIDTH-1:0]       cur_top_tskid;
    logic                         mismatch;

    // shown ids fall back to idle
    assign cur_run_tskid = run_valid ? run_tskid : idle_tskid;
    assign cur_top_tskid = rdq_i.top_valid ? rdq_i.top_tskid : idle_tskid;
    assign mismatch      = cur_run_tskid != cur_top_tskid;

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_tskid  <= '0;
            run_valid  <= 1'b0;
            idle_tskid <= INIT_IDLE_TSKID;
            irq_en     <= 1'b0;
            irq_force  <= 1'b0;
            scratch    <= '0;
        end else begin
            if (cpu_wr_i.wr) begin
                case (cpu_wr_i.id)
                    CTL_RUN_TSKID: begin
                        run_tskid <= cpu_wr_i.dat[TSKID_WIDTH-1:0];
                        run_valid <= cpu_wr_i.dat < WB_DAT_WIDTH'(TASKS);
                    end
                    CTL_RUN_VALID:  run_valid  <= cpu_wr_i.dat[0];
                    CTL_IDLE_TSKID: idle_tskid <= cpu_wr_i.dat[TSKID_WIDTH-1:0];
                    CTL_IRQ_EN:     irq_en     <= cpu_wr_i.dat[0];
                    CTL_IRQ_FORCE:  irq_force  <= cpu_wr_i.dat[0];
                    CTL_SCRATCH0:   scratch[0] <= cpu_wr_i.dat;
                    CTL_SCRATCH1:   scratch[1] <= cpu_wr_i.dat;
                    CTL_SCRATCH2:   scratch[2] <= cpu_wr_i.dat;
                    CTL_SCRATCH3:   scratch[3] <= cpu_wr_i.dat;
                    default: ;
                endcase
            end
            if (copy_rd_i) begin
                run_tskid <= rdq_i.top_tskid;
                run_valid <= rdq_i.top_valid;
            end
        end
    end

    // --------------------
    // switch request
    // --------------------
    // two mismatched edges in a row before irq rises
    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_switch <= 1'b0;
            reg_irq    <= 1'b0;
        end else begin
            reg_switch <= mismatch;
            reg_irq    <= mismatch && reg_switch;
        end
    end

    assign irq_o = (reg_irq && irq_en) || irq_force;

    assign cpu_o.run_tskid  = cur_run_tskid;
    assign cpu_o.run_valid  = run_valid;
    assign cpu_o.top_tskid  = cur_top_tskid;
    assign cpu_o.idle_tskid = idle_tskid;
    assign cpu_o.irq_en     = irq_en;
    assign cpu_o.irq        = irq_o;
    assign cpu_o.scratch    = scratch;

endmodule

// File: source/rtos_event_flags.sv
// event flag word with set, clear by mask and external flag merge
`timescale 1ns/1ns

module rtos_event_flags (
    input  logic                               clk,
    input  logic                               reset_i,
    input  rtos_pkg::flg_cmd_t                 flg_cmd_i,
    input  logic [rtos_pkg::FLGPTN_WIDTH-1:0]  ext_flg_i,
    output logic [rtos_pkg::FLGPTN_WIDTH-1:0]  flgptn_o
);
    import rtos_pkg::*;

    logic [FLGPTN_WIDTH-1:0] flgptn;
    logic [FLGPTN_WIDTH-1:0] ext_ena;
    logic [FLGPTN_WIDTH-1:0] set_mask;
    logic [FLGPTN_WIDTH-1:0] keep_mask;

    assign set_mask  = flg_cmd_i.set ? flg_cmd_i.flgptn : '0;
    assign keep_mask = flg_cmd_i.clr ? flg_cmd_i.flgptn : '1;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            flgptn  <= '0;
            ext_ena <= '0;
        end else begin
            // enabled external inputs merge in every edge
            flgptn <= ((flgptn | set_mask) & keep_mask) | (ext_flg_i & ext_ena);
            if (flg_cmd_i.ena_wr) begin
                ext_ena <= flg_cmd_i.flgptn;
            end
        end
    end

    assign flgptn_o = flgptn;

endmodule

// File: source/rtos_semaphores.sv
// bank of counting semaphores with signal and poll
`timescale 1ns/1ns

module rtos_semaphores (
    input  logic                  clk,
    input  logic                  reset_i,
    input  rtos_pkg::sem_cmd_t    sem_cmd_i,
    output rtos_pkg::semcnt_vec_t semcnt_o,
    output logic                  pol_ok_o
);
    import rtos_pkg::*;

    semcnt_vec_t              semcnt;
    logic [SEMCNT_WIDTH-1:0]  sel_cnt;

    assign sel_cnt  = semcnt[sem_cmd_i.semid];
    assign pol_ok_o = sel_cnt != '0;
    assign semcnt_o = semcnt;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            semcnt <= '0;
        end else begin
            // signal saturates
            if (sem_cmd_i.sig && sel_cnt != SEMCNT_WIDTH'(SEMCNT_MAX)) begin
                semcnt[sem_cmd_i.semid] <= sel_cnt + 1'b1;
            end
            // poll only takes a count that is there
            if (sem_cmd_i.pol && pol_ok_o) begin
                semcnt[sem_cmd_i.semid] <= sel_cnt - 1'b1;
            end
        end
    end

endmodule

// File: source/rtos_ready_queue.sv
// ready task bitmap with lowest-id top selection
`timescale 1ns/1ns

module rtos_ready_queue (
    input  logic                  clk,
    input  logic                  reset_i,
    input  rtos_pkg::task_cmd_t   task_cmd_i,
    output rtos_pkg::rdq_status_t rdq_o
);
    import rtos_pkg::*;

    logic [TASKS-1:0] ready;

    // ids arrive range checked
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ready <= '0;
        end else begin
            if (task_cmd_i.wake) begin
                ready[task_cmd_i.tskid] <= 1'b1;
            end
            if (task_cmd_i.sleep) begin
                ready[task_cmd_i.tskid] <= 1'b0;
            end
        end
    end

    // lowest id wins, so scan downwards
    always_comb begin
        rdq_o.top_tskid = '0;
        rdq_o.top_valid = 1'b0;
        for (int i = TASKS - 1; i >= 0; i--) begin
            if (ready[i]) begin
                rdq_o.top_tskid = TSKID_WIDTH'(i);
                rdq_o.top_valid = 1'b1;
            end
        end
    end

endmodule

// File: source/rtos_bus_decode.sv
// wishbone slave decode into kernel command strobes, plus the read data mux
`timescale 1ns/1ns

module rtos_bus_decode (
    input  rtos_pkg::wb_req_t                  wb_req_i,
    input  rtos_pkg::rdq_status_t              rdq_i,
    input  rtos_pkg::cpu_status_t              cpu_i,
    input  rtos_pkg::semcnt_vec_t              semcnt_i,
    input  logic                               pol_ok_i,
    output logic [rtos_pkg::WB_DAT_WIDTH-1:0]  wb_dat_o,
    output logic                               wb_ack_o,
    output rtos_pkg::task_cmd_t                task_cmd_o,
    output rtos_pkg::sem_cmd_t                 sem_cmd_o,
    output rtos_pkg::flg_cmd_t                 flg_cmd_o,
    output rtos_pkg::cpu_wr_t                  cpu_wr_o,
    output logic                               copy_rd_o
);
    import rtos_pkg::*;

    opcode_e             dec_opcode;
    logic [ID_WIDTH-1:0] dec_id;
    logic                wr_ok;
    logic                rd_full;
    logic                tsk_in_range;
    logic                sem_in_range;

    assign dec_opcode = opcode_e'(wb_req_i.adr[ID_WIDTH +: OPCODE_WIDTH]);
    assign dec_id     = wb_req_i.adr[ID_WIDTH-1:0];

    // no wait states
    assign wb_ack_o = wb_req_i.stb;
    assign wr_ok    = wb_ack_o && wb_req_i.we && (&wb_req_i.sel);
    assign rd_full  = wb_ack_o && !wb_req_i.we && (&wb_req_i.sel);

    assign tsk_in_range = dec_id < ID_WIDTH'(TASKS);
    assign sem_in_range = dec_id < ID_WIDTH'(SEMAPHORES);

    // --------------------
    // command strobes
    // --------------------
    assign task_cmd_o.wake  = wr_ok && dec_opcode == OP_WUP_TSK && tsk_in_range;
    assign task_cmd_o.sleep = wr_ok && dec_opcode == OP_SLP_TSK && tsk_in_range;
    assign task_cmd_o.tskid = dec_id[TSKID_WIDTH-1:0];

    assign sem_cmd_o.sig   = wr_ok && dec_opcode == OP_SIG_SEM && sem_in_range;
    assign sem_cmd_o.pol   = rd_full && dec_opcode == OP_POL_SEM && sem_in_range;
    assign sem_cmd_o.semid = dec_id[SEMID_WIDTH-1:0];

    assign flg_cmd_o.set    = wr_ok && dec_opcode == OP_SET_FLG;
    assign flg_cmd_o.clr    = wr_ok && dec_opcode == OP_CLR_FLG;
    assign flg_cmd_o.ena_wr = wr_ok && dec_opcode == OP_ENA_FLG_EXT;
    assign flg_cmd_o.flgptn = wb_req_i.dat[FLGPTN_WIDTH-1:0];

    assign cpu_wr_o.wr  = wr_ok && dec_opcode == OP_CPU_CTL;
    assign cpu_wr_o.id  = cpu_ctl_id_e'(dec_id);
    assign cpu_wr_o.dat = wb_req_i.dat;

    // reading the copy register moves top into run
    assign copy_rd_o = wb_ack_o && !wb_req_i.we && dec_opcode == OP_CPU_CTL
                       && cpu_ctl_id_e'(dec_id) == CTL_COPY_TSKID;

    // --------------------
    // read mux
    // --------------------
    always_comb begin
        wb_dat_o = '0;
        case (dec_opcode)
            OP_SYS_CFG: begin
                case (sys_cfg_id_e'(dec_id))
                    CFG_CORE_ID:      wb_dat_o = CORE_ID_VALUE;
                    CFG_VERSION:      wb_dat_o = VERSION_VALUE;
                    CFG_DATE:         wb_dat_o = DATE_VALUE;
                    CFG_TASKS:        wb_dat_o = WB_DAT_WIDTH'(TASKS);
                    CFG_SEMAPHORES:   wb_dat_o = WB_DAT_WIDTH'(SEMAPHORES);
                    CFG_SEMCNT_WIDTH: wb_dat_o = WB_DAT_WIDTH'(SEMCNT_WIDTH);
                    CFG_FLGPTN_WIDTH: wb_dat_o = WB_DAT_WIDTH'(FLGPTN_WIDTH);
                    default:          wb_dat_o = '0;
                endcase
            end
            OP_CPU_CTL: begin
                case (cpu_ctl_id_e'(dec_id))
                    CTL_TOP_TSKID:  wb_dat_o = WB_DAT_WIDTH'(cpu_i.top_tskid);
                    CTL_TOP_VALID:  wb_dat_o = WB_DAT_WIDTH'(rdq_i.top_valid);
                    CTL_RUN_TSKID:  wb_dat_o = WB_DAT_WIDTH'(cpu_i.run_tskid);
                    CTL_RUN_VALID:  wb_dat_o = WB_DAT_WIDTH'(cpu_i.run_valid);
                    CTL_IDLE_TSKID: wb_dat_o = WB_DAT_WIDTH'(cpu_i.idle_tskid);
                    CTL_COPY_TSKID: wb_dat_o = WB_DAT_WIDTH'(cpu_i.run_tskid);
                    CTL_IRQ_EN:     wb_dat_o = WB_DAT_WIDTH'(cpu_i.irq_en);
                    CTL_IRQ_STS:    wb_dat_o = WB_DAT_WIDTH'(cpu_i.irq);
                    CTL_SCRATCH0:   wb_dat_o = cpu_i.scratch[0];
                    CTL_SCRATCH1:   wb_dat_o = cpu_i.scratch[1];
                    CTL_SCRATCH2:   wb_dat_o = cpu_i.scratch[2];
                    CTL_SCRATCH3:   wb_dat_o = cpu_i.scratch[3];
                    default:        wb_dat_o = '0;
                endcase
            end
            // result before the decrement lands
            OP_POL_SEM:    wb_dat_o = WB_DAT_WIDTH'(pol_ok_i && sem_in_range);
            OP_REF_SEMCNT: wb_dat_o = WB_DAT_WIDTH'(semcnt_i);
            default:       wb_dat_o = '0;
        endcase
    end

endmodule

// File: source/rtos_pkg.sv
// rtos helper package: bus sizes, object sizes, address map and shared structs
package rtos_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int WB_ADR_WIDTH = 16;
    localparam int WB_DAT_WIDTH = 32;
    localparam int WB_SEL_WIDTH = 4;

    localparam int TASKS        = 15;
    localparam int SEMAPHORES   = 8;
    localparam int TSKID_WIDTH  = 4;
    localparam int SEMID_WIDTH  = 3;
    localparam int SEMCNT_WIDTH = 4;
    localparam int SEMCNT_MAX   = 15;
    localparam int FLGPTN_WIDTH = 32;

    // address split, id in the low byte and opcode above it
    localparam int ID_WIDTH     = 8;
    localparam int OPCODE_WIDTH = 8;

    localparam logic [TSKID_WIDTH-1:0]  INIT_IDLE_TSKID = 4'd15;
    localparam logic [WB_DAT_WIDTH-1:0] CORE_ID_VALUE   = 32'h834f5452;
    localparam logic [WB_DAT_WIDTH-1:0] VERSION_VALUE   = 32'h00000000;
    localparam logic [WB_DAT_WIDTH-1:0] DATE_VALUE      = 32'h20211120;

    // --------------------
    // address map
    // --------------------
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_SYS_CFG     = 8'h00,
        OP_CPU_CTL     = 8'h01,
        OP_WUP_TSK     = 8'h10,
        OP_SLP_TSK     = 8'h11,
        OP_SIG_SEM     = 8'h21,
        OP_POL_SEM     = 8'h23,
        OP_REF_SEMCNT  = 8'h28,
        OP_SET_FLG     = 8'h31,
        OP_CLR_FLG     = 8'h32,
        OP_ENA_FLG_EXT = 8'h3a
    } opcode_e;

    typedef enum logic [ID_WIDTH-1:0] {
        CFG_CORE_ID      = 8'h00,
        CFG_VERSION      = 8'h01,
        CFG_DATE         = 8'h04,
        CFG_TASKS        = 8'h20,
        CFG_SEMAPHORES   = 8'h21,
        CFG_SEMCNT_WIDTH = 8'h31,
        CFG_FLGPTN_WIDTH = 8'h32
    } sys_cfg_id_e;

    typedef enum logic [ID_WIDTH-1:0] {
        CTL_TOP_TSKID  = 8'h00,
        CTL_TOP_VALID  = 8'h01,
        CTL_RUN_TSKID  = 8'h04,
        CTL_RUN_VALID  = 8'h05,
        CTL_IDLE_TSKID = 8'h07,
        CTL_COPY_TSKID = 8'h08,
        CTL_IRQ_EN     = 8'h10,
        CTL_IRQ_STS    = 8'h11,
        CTL_IRQ_FORCE  = 8'h1f,
        CTL_SCRATCH0   = 8'he0,
        CTL_SCRATCH1   = 8'he1,
        CTL_SCRATCH2   = 8'he2,
        CTL_SCRATCH3   = 8'he3
    } cpu_ctl_id_e;

    // --------------------
    // structs
    // --------------------
    typedef logic [SEMAPHORES-1:0][SEMCNT_WIDTH-1:0] semcnt_vec_t;

    typedef struct packed {
        logic [WB_ADR_WIDTH-1:0] adr;
        logic [WB_DAT_WIDTH-1:0] dat;
        logic                    we;
        logic [WB_SEL_WIDTH-1:0] sel;
        logic                    stb;
    } wb_req_t;

    typedef struct packed {
        logic                   wake;
        logic                   sleep;
        logic [TSKID_WIDTH-1:0] tskid;
    } task_cmd_t;

    typedef struct packed {
        logic                   sig;
        logic                   pol;
        logic [SEMID_WIDTH-1:0] semid;
    } sem_cmd_t;

    typedef struct packed {
        logic                    set;
        logic                    clr;
        logic                    ena_wr;
        logic [FLGPTN_WIDTH-1:0] flgptn;
    } flg_cmd_t;

    typedef struct packed {
        logic                    wr;
        cpu_ctl_id_e             id;
        logic [WB_DAT_WIDTH-1:0] dat;
    } cpu_wr_t;

    typedef struct packed {
        logic [TSKID_WIDTH-1:0] top_tskid;
        logic                   top_valid;
    } rdq_status_t;

    // ids here are the shown ones, idle id when not valid
    typedef struct packed {
        logic [TSKID_WIDTH-1:0]        run_tskid;
        logic                          run_valid;
        logic [TSKID_WIDTH-1:0]        top_tskid;
        logic [TSKID_WIDTH-1:0]        idle_tskid;
        logic                          irq_en;
        logic                          irq;
        logic [3:0][WB_DAT_WIDTH-1:0]  scratch;
    } cpu_status_t;

    typedef struct packed {
        logic [TSKID_WIDTH-1:0]  top_tskid;
        logic                    top_valid;
        logic [TSKID_WIDTH-1:0]  run_tskid;
        logic                    run_valid;
        semcnt_vec_t             semcnt;
        logic [FLGPTN_WIDTH-1:0] flgptn;
        logic [WB_DAT_WIDTH-1:0] scratch0;
    } rtos_monitor_t;

endpackage
